// ==== cps2_defines.svh ====
/* Bus widths and address region constants for the CPS-2 main bus glue
   Included by the package and by every module that decodes the address */
`ifndef CPS2_DEFINES_SVH
`define CPS2_DEFINES_SVH

`define CPS2_ADDR_W  23       // Word address A23..A1
`define CPS2_DATA_W  16
`define CPS2_ROM_W   21       // ROM word address A21..A1
`define CPS2_JOY_W   10
`define CPS2_VOL_W   13       // QSound volume readback

// Region codes on the top bits of the byte address
`define CPS2_ROM_TOP     2'b00      // A[23:22], below 0x400000
`define CPS2_OBJCFG_NIB  4'h4       // A[23:20], writes only
`define CPS2_QS_NIB      4'h6       // A[23:20] and A[19:17] zero
`define CPS2_ORAM_NIB    4'h7       // A[23:20] and page match
`define CPS2_IO_TOP      5'b1000_0  // A[23:19], 0x800000 up to 0x87FFFF
`define CPS2_VRAM_TOP    6'b1001_00 // A[23:18] and A[17:16] not 3
`define CPS2_WRAM_TOP    8'hFF      // A[23:16]

// One wait state below LO or from HI upwards
`define CPS2_SLOW_LO     4'h5
`define CPS2_SLOW_HI     4'h8

// I/O page offsets on A[8:3], PPU selects on A[8:6]
`define CPS2_IO_IN0      6'h00
`define CPS2_IO_IN1      6'h02
`define CPS2_IO_IN2      6'h04
`define CPS2_IO_VOL      6'h06
`define CPS2_IO_OUT      6'h08      // Z80 reset low byte, EEPROM high byte
`define CPS2_IO_OBANK    6'h1C
`define CPS2_IO_PPU1     3'b100
`define CPS2_IO_PPU2     3'b101

`endif

// ==== cps2_pkg.sv ====
/* Shared types of the main bus glue
   Modules pull them in with a wildcard import in their header */
`include "cps2_defines.svh"

package cps2_pkg;

    // Word address, bit 0 of the byte address comes from the strobes
    typedef logic [`CPS2_ADDR_W:1]   addr_t;

    typedef logic [`CPS2_DATA_W-1:0] data_t;

    typedef logic [`CPS2_ROM_W:1]    rom_addr_t;  // ROM word address

    // Cabinet joystick, active low
    // Bits 3:0 directions, 9:4 buttons 1 to 6
    typedef logic [`CPS2_JOY_W-1:0]  joy_t;

    // Any code other than zero is four-button wiring
    typedef enum logic [1:0] {
        but6 = 2'd0,
        but4 = 2'd1
    } joy_mode_e;

    // DTACK generation
    typedef enum logic [2:0] {
        idle,        // No cycle
        select,      // Selects being registered
        wait_ready,  // Waiting on the target
        wait_one,    // Extra wait in slow regions
        ack          // DTACK low until AS rises
    } cycle_state_e;

endpackage

// ==== cps2_bus_if.sv ====
/* 68000-style bus from the master as seen by the glue blocks
   Driven once at the top level, every block only listens */
`timescale 1ns/100ps

interface cps2_bus_if import cps2_pkg::*; ();

    addr_t addr;
    data_t dout;    // Write data from the master
    logic  rnw;
    logic  udsn;    // Upper byte strobe
    logic  ldsn;
    logic  asn;

    // Decoder needs the whole bus
    modport decode (
        input addr, rnw, udsn, ldsn, asn
    );

    // Register writes qualify by select, so no rnw here
    modport regs (
        input addr, dout, udsn, ldsn
    );

    // Slow region check and cycle end
    modport cycle (
        input addr, asn
    );

endinterface

// ==== cps2_sel_if.sv ====
/* Chip selects of one bus cycle
   The address decoder drives them, registers and DTACK logic consume them */
`timescale 1ns/100ps

interface cps2_sel_if ();

    // Region selects
    logic rom_cs, ram_cs, vram_cs, oram_cs, qs_cs;
    // I/O page
    logic in0_cs, in1_cs, in2_cs, vol_cs;
    logic out_cs, eeprom_cs, obank_cs;  // Writes only
    logic objcfg_cs;                    // Object config, writes only
    logic ppu1_cs, ppu2_cs;

    modport decoder (
        output rom_cs, ram_cs, vram_cs, oram_cs, qs_cs,
               in0_cs, in1_cs, in2_cs, vol_cs,
               out_cs, eeprom_cs, obank_cs, objcfg_cs,
               ppu1_cs, ppu2_cs
    );

    modport regs (
        input in0_cs, in1_cs, in2_cs,
              out_cs, eeprom_cs, obank_cs, objcfg_cs
    );

    // What the read mux and ready logic look at
    modport cycle (
        input rom_cs, ram_cs, vram_cs, oram_cs, qs_cs,
              in0_cs, in1_cs, in2_cs, vol_cs, ppu2_cs
    );

endinterface

// ==== cps2_addr_decode.sv ====
/* Address decoder of the main bus
   Region selects are registered while AS is low and cleared between cycles
   I/O page sub-selects follow combinationally from the registered page select */
`timescale 1ns/100ps
`include "cps2_defines.svh"

module cps2_addr_decode import cps2_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    cps2_bus_if.decode    bus,
    cps2_sel_if.decoder   sel,
    input  logic [3:0]    oram_page,   // Object RAM page from oram_base
    output rom_addr_t     rom_addr,
    output addr_t         qs_addr
);

    logic       io_cs;      // Whole I/O page
    logic [5:0] io_off;
    logic       wr_lo;
    logic       wr_hi;

    assign io_off = bus.addr[8:3];
    assign wr_lo  = !bus.rnw && !bus.ldsn;
    assign wr_hi  = !bus.rnw && !bus.udsn;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel.rom_cs    <= 1'b0;
            sel.ram_cs    <= 1'b0;
            sel.vram_cs   <= 1'b0;
            sel.oram_cs   <= 1'b0;
            sel.qs_cs     <= 1'b0;
            sel.objcfg_cs <= 1'b0;
            io_cs         <= 1'b0;
        end else if (!bus.asn) begin
            sel.rom_cs    <= bus.addr[23:22] == `CPS2_ROM_TOP;
            sel.ram_cs    <= bus.addr[23:16] == `CPS2_WRAM_TOP;
            sel.vram_cs   <= bus.addr[23:18] == `CPS2_VRAM_TOP && bus.addr[17:16] != 2'b11;
            sel.oram_cs   <= bus.addr[23:20] == `CPS2_ORAM_NIB
                             && bus.addr[19:16] == oram_page;
            sel.qs_cs     <= bus.addr[23:20] == `CPS2_QS_NIB && bus.addr[19:17] == 3'd0;
            sel.objcfg_cs <= bus.addr[23:20] == `CPS2_OBJCFG_NIB && !bus.rnw;
            io_cs         <= bus.addr[23:19] == `CPS2_IO_TOP;
        end else begin
            sel.rom_cs    <= 1'b0;
            sel.ram_cs    <= 1'b0;
            sel.vram_cs   <= 1'b0;
            sel.oram_cs   <= 1'b0;
            sel.qs_cs     <= 1'b0;
            sel.objcfg_cs <= 1'b0;
            io_cs         <= 1'b0;
        end
    end

    // Memory side addresses, stable for the rest of the cycle
    always_ff @(posedge clk) begin
        if (!bus.asn) begin
            rom_addr <= bus.addr[`CPS2_ROM_W:1];
            qs_addr  <= bus.addr;
        end
    end

    assign sel.ppu1_cs   = io_cs && bus.addr[8:6] == `CPS2_IO_PPU1;  // CPS-A registers
    assign sel.ppu2_cs   = io_cs && bus.addr[8:6] == `CPS2_IO_PPU2;  // CPS-B registers
    assign sel.in0_cs    = io_cs && io_off == `CPS2_IO_IN0;
    assign sel.in1_cs    = io_cs && io_off == `CPS2_IO_IN1;
    assign sel.in2_cs    = io_cs && io_off == `CPS2_IO_IN2;
    assign sel.vol_cs    = io_cs && io_off == `CPS2_IO_VOL;

    // Same word, byte lane picks the register
    assign sel.out_cs    = io_cs && io_off == `CPS2_IO_OUT && wr_lo;
    assign sel.eeprom_cs = io_cs && io_off == `CPS2_IO_OUT && wr_hi;
    assign sel.obank_cs  = io_cs && io_off == `CPS2_IO_OBANK && wr_lo;

endmodule

// ==== cps2_io_regs.sv ====
/* Writable I/O registers and cabinet input words
   Writes land on the acknowledge edge of the bus cycle
   sys_data returns the selected input word to the read mux */
`timescale 1ns/100ps

module cps2_io_regs import cps2_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    cps2_bus_if.regs    bus,
    cps2_sel_if.regs    sel,
    input  logic        wr_en,          // High in the cycle before DTACK falls
    input  joy_mode_e   joymode,
    input  joy_t        joystick1,
    input  joy_t        joystick2,
    input  joy_t        joystick3,
    input  joy_t        joystick4,
    input  logic [3:0]  start_button,
    input  logic [3:0]  coin_input,
    input  logic        service,
    input  logic        dip_test,
    input  logic        eeprom_sdo,
    output data_t       sys_data,
    output logic        eeprom_sclk,
    output logic        eeprom_sdi,
    output logic        eeprom_scs,
    output logic        z80_rstn,
    output logic        obank,
    output data_t       oram_base
);

    data_t in0;
    data_t in1;
    data_t in2;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            eeprom_scs  <= 1'b0;
            eeprom_sclk <= 1'b0;
            eeprom_sdi  <= 1'b0;
            z80_rstn    <= 1'b0;   // Sound CPU held until the game releases it
            obank       <= 1'b0;
            oram_base   <= '0;
        end else if (wr_en) begin
            if (sel.eeprom_cs) begin
                eeprom_sdi  <= bus.dout[12];
                eeprom_sclk <= bus.dout[13];
                eeprom_scs  <= bus.dout[14];
            end
            if (sel.out_cs)
                z80_rstn <= bus.dout[3];
            if (sel.obank_cs)
                obank <= bus.dout[0];
            if (sel.objcfg_cs && bus.addr[3:1] == 3'd0) begin
                if (!bus.udsn) oram_base[15:8] <= bus.dout[15:8];
                if (!bus.ldsn) oram_base[7:0]  <= bus.dout[7:0];
            end
        end
    end

    // Buttons 4 to 6 move into spare bits on six-button cabinets
    always_ff @(posedge clk) begin
        if (joymode == but6) begin
            in0 <= {1'b1, joystick2[6:0], 1'b1, joystick1[6:0]};
            in1 <= {10'h3ff, joystick2[8:7], 1'b1, joystick1[9:7]};
            in2 <= {coin_input[3], joystick2[9], coin_input[1:0], start_button,
                    5'h1f, service, dip_test, eeprom_sdo};
        end else begin
            in0 <= {joystick2[7:0], joystick1[7:0]};
            in1 <= {joystick4[7:0], joystick3[7:0]};   // Players 3 and 4
            in2 <= {coin_input, start_button, 5'h1f, service, dip_test, eeprom_sdo};
        end
    end

    assign sys_data = sel.in0_cs ? in0 :
                      sel.in1_cs ? in1 :
                      sel.in2_cs ? in2 : 16'hffff;

endmodule

// ==== cps2_bus_cycle.sv ====
/* DTACK generation and read data latch of the main bus
   Waits for the selected target to be ready, adds one wait in slow regions,
   then holds DTACK low with the read word until AS rises */
`timescale 1ns/100ps
`include "cps2_defines.svh"

module cps2_bus_cycle import cps2_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    cps2_bus_if.cycle              bus,
    cps2_sel_if.cycle              sel,
    input  data_t                  sys_data,
    input  data_t                  ram_data,
    input  data_t                  rom_data,
    input  data_t                  mmr_dout,
    input  logic [7:0]             qs_din,
    input  logic [`CPS2_VOL_W-1:0] volume,
    input  logic                   ram_ok,
    input  logic                   rom_ok,
    input  logic                   qs_waitn,
    output logic                   dtack_n,
    output logic                   wr_en,
    output data_t                  cpu_din
);

    cycle_state_e state;
    cycle_state_e state_nx;
    logic         slow;
    logic         ready;
    logic         go_ack;
    data_t        rd_mux;

    assign slow  = bus.addr[23:20] < `CPS2_SLOW_LO || bus.addr[23:20] >= `CPS2_SLOW_HI;

    // I/O, OBJCFG and unmapped space never hold the bus
    assign ready = !((sel.rom_cs && !rom_ok)
                  || ((sel.ram_cs || sel.vram_cs || sel.oram_cs) && !ram_ok)
                  || (sel.qs_cs && !qs_waitn));

    always_comb begin
        state_nx = state;
        case (state)
            idle:       if (!bus.asn) state_nx = select;
            select:     state_nx = wait_ready;
            wait_ready: if (ready) state_nx = slow ? wait_one : ack;
            wait_one:   state_nx = ack;
            ack:        state_nx = ack;
            default:    state_nx = idle;
        endcase
        if (bus.asn)
            state_nx = idle;    // Master ended or dropped the cycle
    end

    assign go_ack = state_nx == ack && state != ack;
    assign wr_en  = go_ack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= idle;
            dtack_n <= 1'b1;
        end else begin
            state   <= state_nx;
            dtack_n <= state_nx != ack;
        end
    end

    always_comb begin
        if (sel.in0_cs || sel.in1_cs || sel.in2_cs) rd_mux = sys_data;
        else if (sel.ram_cs || sel.vram_cs || sel.oram_cs) rd_mux = ram_data;
        else if (sel.rom_cs)  rd_mux = rom_data;
        else if (sel.ppu2_cs) rd_mux = mmr_dout;
        else if (sel.vol_cs)  rd_mux = {3'b111, volume};
        else if (sel.qs_cs)   rd_mux = {8'hff, qs_din};   // Byte-wide sound RAM
        else                  rd_mux = 16'hffff;
    end

    // Captured with DTACK and held until the next acknowledge
    always_ff @(posedge clk) begin
        if (go_ack)
            cpu_din <= rd_mux;
    end

endmodule

// ==== cps2_main_bus.sv ====
/* Main CPU bus glue of a CPS-2 style board
   Takes the 68000 bus from an external master, returns DTACK and read data,
   and drives chip selects and I/O register outputs toward the rest of the board */
`timescale 1ns/100ps
`include "cps2_defines.svh"

module cps2_main_bus import cps2_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    // CPU bus
    input  addr_t                  addr,
    input  data_t                  cpu_dout,
    input  logic                   rnw,
    input  logic                   udsn,
    input  logic                   ldsn,
    input  logic                   asn,
    output logic                   dtack_n,
    output data_t                  cpu_din,
    // Cabinet inputs
    input  joy_mode_e              joymode,
    input  joy_t                   joystick1,
    input  joy_t                   joystick2,
    input  joy_t                   joystick3,
    input  joy_t                   joystick4,
    input  logic [3:0]             start_button,
    input  logic [3:0]             coin_input,
    input  logic                   service,
    input  logic                   dip_test,
    // ROM and RAM
    output logic                   rom_cs,
    output rom_addr_t              rom_addr,
    input  data_t                  rom_data,
    input  logic                   rom_ok,
    output logic                   ram_cs,
    output logic                   vram_cs,
    output logic                   oram_cs,
    input  data_t                  ram_data,
    input  logic                   ram_ok,
    // Video chips
    output logic                   ppu1_cs,
    output logic                   ppu2_cs,
    input  data_t                  mmr_dout,
    // QSound
    output logic                   qs_cs,
    output addr_t                  qs_addr,
    input  logic [7:0]             qs_din,
    input  logic [`CPS2_VOL_W-1:0] volume,
    input  logic                   qs_waitn,
    output logic                   z80_rstn,
    // Serial EEPROM
    output logic                   eeprom_sclk,
    output logic                   eeprom_sdi,
    output logic                   eeprom_scs,
    input  logic                   eeprom_sdo,
    // Object engine
    output logic                   obank,
    output data_t                  oram_base
);

    cps2_bus_if bus ();
    cps2_sel_if sel ();

    data_t sys_data;    // Input word for the read mux
    logic  wr_en;

    assign bus.addr = addr;
    assign bus.dout = cpu_dout;
    assign bus.rnw  = rnw;
    assign bus.udsn = udsn;
    assign bus.ldsn = ldsn;
    assign bus.asn  = asn;

    assign rom_cs  = sel.rom_cs;
    assign ram_cs  = sel.ram_cs;
    assign vram_cs = sel.vram_cs;
    assign oram_cs = sel.oram_cs;
    assign ppu1_cs = sel.ppu1_cs;
    assign ppu2_cs = sel.ppu2_cs;
    assign qs_cs   = sel.qs_cs;

    // Ports connect by name, object page comes from oram_base
    cps2_addr_decode u_decode (
        .*,
        .oram_page ( oram_base[11:8] )
    );

    cps2_io_regs u_regs (.*);

    cps2_bus_cycle u_cycle (.*);

endmodule

// ==== cps2_bus_checker.sv ====
/* Concurrent assertions on the DTACK logic of the main bus
   Bound into every bus cycle block of the design */
`timescale 1ns/100ps

module cps2_bus_checker (
    input logic clk,
    input logic rst,
    input logic asn,
    input logic dtack_n,
    input logic wr_en,
    input logic rom_cs,
    input logic mem_cs,     // Any of the three RAM selects
    input logic qs_cs,
    input logic rom_ok,
    input logic ram_ok,
    input logic qs_waitn
);

    int   assert_fails = 0;
    logic target_ready;

    assign target_ready = !(rom_cs && !rom_ok) && !(mem_cs && !ram_ok) && !(qs_cs && !qs_waitn);

    // DTACK released on the edge after AS rises
    ack_release: assert property (@(posedge clk) disable iff (rst)
        asn && !dtack_n |=> dtack_n)
        else begin
            assert_fails++;
            $error("dtack_n still low one edge after AS rose");
        end

    ack_ready: assert property (@(posedge clk) disable iff (rst)
        !dtack_n |-> target_ready)
        else begin
            assert_fails++;
            $error("dtack_n low while the selected target is not ready");
        end

    // Register write strobe
    wr_single: assert property (@(posedge clk) disable iff (rst)
        wr_en |=> !wr_en)
        else begin
            assert_fails++;
            $error("wr_en high for more than one cycle");
        end

endmodule

bind cps2_bus_cycle cps2_bus_checker u_checker (
    .clk      ( clk ),
    .rst      ( rst ),
    .asn      ( bus.asn ),
    .dtack_n  ( dtack_n ),
    .wr_en    ( wr_en ),
    .rom_cs   ( sel.rom_cs ),
    .mem_cs   ( sel.ram_cs || sel.vram_cs || sel.oram_cs ),
    .qs_cs    ( sel.qs_cs ),
    .rom_ok   ( rom_ok ),
    .ram_ok   ( ram_ok ),
    .qs_waitn ( qs_waitn )
);

// ==== tb_cps2_main_bus.sv ====
/* Testbench for the CPS-2 main bus glue
   Acts as 68000 bus master and as ROM/RAM model, runs a table of bus cycles
   and checks selects, DTACK timing, read data and register outputs */
`timescale 1ns/100ps
`include "cps2_defines.svh"

module tb_cps2_main_bus import cps2_pkg::*; ();

    logic                   clk;
    logic                   rst;
    addr_t                  addr;
    data_t                  cpu_dout;
    logic                   rnw, udsn, ldsn, asn;
    logic                   dtack_n;
    data_t                  cpu_din;
    joy_mode_e              joymode;
    joy_t                   joystick1, joystick2, joystick3, joystick4;
    logic [3:0]             start_button, coin_input;
    logic                   service, dip_test, eeprom_sdo;
    logic                   rom_cs, ram_cs, vram_cs, oram_cs, ppu1_cs, ppu2_cs, qs_cs;
    rom_addr_t              rom_addr;
    addr_t                  qs_addr;
    data_t                  rom_data = '0;
    data_t                  ram_data = '0;
    logic                   rom_ok = 1'b0;
    logic                   ram_ok = 1'b0;
    data_t                  mmr_dout;
    logic [7:0]             qs_din;
    logic [`CPS2_VOL_W-1:0] volume;
    logic                   qs_waitn;
    logic                   z80_rstn, eeprom_sclk, eeprom_sdi, eeprom_scs, obank;
    data_t                  oram_base;

    localparam logic [6:0] cs_none = 7'h00;
    localparam logic [6:0] cs_rom  = 7'h01;
    localparam logic [6:0] cs_ram  = 7'h02;
    localparam logic [6:0] cs_vram = 7'h04;
    localparam logic [6:0] cs_oram = 7'h08;
    localparam logic [6:0] cs_ppu1 = 7'h10;
    localparam logic [6:0] cs_ppu2 = 7'h20;
    localparam logic [6:0] cs_qs   = 7'h40;

    typedef struct {
        logic [23:0] a;     // Byte address
        logic        wr;
        logic [1:0]  dsn;   // {udsn, ldsn}
        data_t       wd;
        logic [6:0]  cs;    // {qs, ppu2, ppu1, oram, vram, ram, rom}
        data_t       rd;
        logic        slow;
        logic        rnd;   // Random ROM/RAM ready delay
        joy_mode_e   mode;
        logic [4:0]  ctl;   // {scs, sclk, sdi, z80_rstn, obank} after the cycle
        data_t       base;
    } entry_t;

    entry_t     entries[$];
    entry_t     e;
    int         cyc = 0;
    int         ok_cyc = 0;
    int         rdy_delay = 0;
    int         wait_cnt = 0;
    int         errors = 0;
    int         errs_before;
    int         start_cyc;
    int         i;
    logic       seen;
    logic       timed_out = 1'b0;
    logic [6:0] cs_seen;
    logic [4:0] ctl_seen;

    assign cs_seen  = {qs_cs, ppu2_cs, ppu1_cs, oram_cs, vram_cs, ram_cs, rom_cs};
    assign ctl_seen = {eeprom_scs, eeprom_sclk, eeprom_sdi, z80_rstn, obank};

    cps2_main_bus i_cps2_main_bus (.*);

    // Memory contents, every address bit shows up in the word
    function automatic data_t rom_fill(input logic [21:0] b);
        return b[16:1] ^ {b[21:17], 11'h0} ^ 16'ha5c3;
    endfunction

    function automatic data_t ram_fill(input logic [23:0] b);
        return b[16:1] ^ {b[23:17], 9'h0} ^ 16'h3c96;
    endfunction

    task automatic add_entry(input logic [23:0] a, input logic wr, input logic [1:0] dsn,
                             input data_t wd, input logic [6:0] cs, input data_t rd,
                             input logic slow, input logic rnd, input joy_mode_e mode,
                             input logic [4:0] ctl, input data_t base);
        entries.push_back('{a, wr, dsn, wd, cs, rd, slow, rnd, mode, ctl, base});
    endtask

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Polls dtack_n on falling edges, gives up after 64 cycles
    task automatic wait_dtack(input logic level, output logic found);
        int n;
        found = 1'b0;
        n = 0;
        while (!found && n < 64) begin
            @(negedge clk);
            n++;
            if (dtack_n === level)
                found = 1'b1;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ROM/RAM model, ready after rdy_delay cycles of select
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (rom_cs)
            rom_data <= rom_fill({rom_addr, 1'b0});
        if (ram_cs || vram_cs || oram_cs)
            ram_data <= ram_fill({addr, 1'b0});
        if (!(rom_cs || ram_cs || vram_cs || oram_cs)) begin
            rom_ok   <= rdy_delay == 0;
            ram_ok   <= rdy_delay == 0;
            wait_cnt <= 0;
        end else if (wait_cnt == rdy_delay) begin
            if (!ram_ok)
                ok_cyc <= cyc + 1;      // Edge on which ready rises
            rom_ok <= 1'b1;
            ram_ok <= 1'b1;
        end else begin
            wait_cnt <= wait_cnt + 1;
        end
    end

    initial begin
        void'($urandom(32'h274a));
        rst          = 1'b1;
        addr         = '0;
        cpu_dout     = '0;
        rnw          = 1'b1;
        udsn         = 1'b1;
        ldsn         = 1'b1;
        asn          = 1'b1;
        joymode      = but4;
        joystick1    = 10'h235;
        joystick2    = 10'h1ca;
        joystick3    = 10'h0f3;
        joystick4    = 10'h36e;
        start_button = 4'b1010;
        coin_input   = 4'b0110;
        service      = 1'b1;
        dip_test     = 1'b0;
        eeprom_sdo   = 1'b1;
        mmr_dout     = 16'h6b21;
        qs_din       = 8'h3d;
        volume       = 13'h0a5c;
        qs_waitn     = 1'b1;

        //        address  wr dsn wdata   select   read data           slw rnd mode ctl  base
        add_entry('h012346, 0, 0, 'h0000, cs_rom, rom_fill('h012346), 1, 0, but4, 'h00, 'h0000);
        add_entry('h1ffffe, 0, 0, 'h0000, cs_rom, rom_fill('h1ffffe), 1, 1, but4, 'h00, 'h0000);
        add_entry('hff1234, 0, 0, 'h0000, cs_ram, ram_fill('hff1234), 1, 0, but4, 'h00, 'h0000);
        add_entry('hff8ace, 0, 0, 'h0000, cs_ram, ram_fill('hff8ace), 1, 1, but4, 'h00, 'h0000);
        add_entry('h900400, 0, 0, 'h0000, cs_vram, ram_fill('h900400), 1, 1, but4, 'h00, 'h0000);
        add_entry('h618000, 0, 0, 'h0000, cs_qs, 'hff3d, 0, 0, but4, 'h00, 'h0000);
        add_entry('h800030, 0, 0, 'h0000, cs_none, 'hea5c, 1, 0, but4, 'h00, 'h0000);
        add_entry('h800140, 0, 0, 'h0000, cs_ppu2, 'h6b21, 1, 0, but4, 'h00, 'h0000);
        add_entry('h800100, 0, 0, 'h0000, cs_ppu1, 'hffff, 1, 0, but4, 'h00, 'h0000);
        add_entry('ha00000, 0, 0, 'h0000, cs_none, 'hffff, 1, 0, but4, 'h00, 'h0000);
        add_entry('h800000, 0, 0, 'h0000, cs_none, 'hca35, 1, 0, but4, 'h00, 'h0000);
        add_entry('h800010, 0, 0, 'h0000, cs_none, 'h6ef3, 1, 0, but4, 'h00, 'h0000);
        add_entry('h800020, 0, 0, 'h0000, cs_none, 'h6afd, 1, 0, but4, 'h00, 'h0000);
        add_entry('h800000, 0, 0, 'h0000, cs_none, 'hcab5, 1, 0, but6, 'h00, 'h0000);
        add_entry('h800010, 0, 0, 'h0000, cs_none, 'hfffc, 1, 0, but6, 'h00, 'h0000);
        add_entry('h800020, 0, 0, 'h0000, cs_none, 'h2afd, 1, 0, but6, 'h00, 'h0000);
        add_entry('h800040, 1, 1, 'h5000, cs_none, 'hffff, 1, 0, but4, 'h14, 'h0000);
        add_entry('h800040, 1, 2, 'h0008, cs_none, 'hffff, 1, 0, but4, 'h16, 'h0000);
        add_entry('h800040, 1, 0, 'h2000, cs_none, 'hffff, 1, 0, but4, 'h08, 'h0000);
        add_entry('h8000e0, 1, 2, 'h0001, cs_none, 'hffff, 1, 0, but4, 'h09, 'h0000);
        add_entry('h400000, 1, 1, 'h0312, cs_none, 'hffff, 1, 0, but4, 'h09, 'h0300);
        add_entry('h400000, 1, 2, 'h47a5, cs_none, 'hffff, 1, 0, but4, 'h09, 'h03a5);
        add_entry('h730010, 0, 0, 'h0000, cs_oram, ram_fill('h730010), 0, 1, but4, 'h09, 'h03a5);
        add_entry('h720010, 0, 0, 'h0000, cs_none, 'hffff, 0, 0, but4, 'h09, 'h03a5);
        add_entry('h400000, 1, 1, 'h0599, cs_none, 'hffff, 1, 0, but4, 'h09, 'h05a5);
        add_entry('h750000, 0, 0, 'h0000, cs_oram, ram_fill('h750000), 0, 0, but4, 'h09, 'h05a5);
        add_entry('h730000, 0, 0, 'h0000, cs_none, 'hffff, 0, 0, but4, 'h09, 'h05a5);

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare("dtack_n after reset", dtack_n, 1'b1);
        compare("selects after reset", cs_seen, cs_none);
        compare("control outputs after reset", ctl_seen, 5'h00);
        compare("oram_base after reset", oram_base, 16'h0000);
        $display("test 0 reset values: %s", errors == 0 ? "ok" : "mismatch");

        for (i = 0; i < entries.size() && !timed_out; i++) begin
            e = entries[i];
            errs_before = errors;
            @(negedge clk);
            rdy_delay = e.rnd ? 1 + $urandom % 6 : 0;
            start_cyc = cyc;
            @(posedge clk);
            joymode  <= e.mode;
            addr     <= e.a[23:1];
            cpu_dout <= e.wd;
            rnw      <= !e.wr;
            udsn     <= e.dsn[1];
            ldsn     <= e.dsn[0];
            asn      <= 1'b0;
            wait_dtack(1'b0, seen);
            if (!seen) begin
                $display("timeout: dtack_n never went low in test %0d", i + 1);
                timed_out = 1'b1;
            end else begin
                // T2 after the drive edge plus one in slow regions
                compare("dtack edge", cyc, e.rnd ? ok_cyc + 1 + e.slow : start_cyc + 4 + e.slow);
                compare("selects", cs_seen, e.cs);
                compare("rom_addr", rom_addr, e.a[21:1]);
                compare("qs_addr", qs_addr, e.a[23:1]);
                if (!e.wr)
                    compare("read data", cpu_din, e.rd);
                compare("control outputs", ctl_seen, e.ctl);
                compare("oram_base", oram_base, e.base);
                @(posedge clk);
                asn  <= 1'b1;
                udsn <= 1'b1;
                ldsn <= 1'b1;
                rnw  <= 1'b1;
                wait_dtack(1'b1, seen);
                if (!seen) begin
                    $display("timeout: dtack_n stayed low after AS rose in test %0d", i + 1);
                    timed_out = 1'b1;
                end else begin
                    compare("selects after the cycle", cs_seen, cs_none);
                end
            end
            $display("test %0d at %h: %s", i + 1, e.a, errors == errs_before ? "ok" : "mismatch");
        end

        $display("%0d tests, %0d errors, %0d assertion failures", i + 1, errors,
                 i_cps2_main_bus.u_cycle.u_checker.assert_fails);
        if (errors == 0 && !timed_out && i_cps2_main_bus.u_cycle.u_checker.assert_fails == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+.
cps2_pkg.sv
cps2_bus_if.sv
cps2_sel_if.sv
cps2_addr_decode.sv
cps2_io_regs.sv
cps2_bus_cycle.sv
cps2_main_bus.sv
cps2_bus_checker.sv
tb_cps2_main_bus.sv

// ==== Bender.yml ====
package:
  name: cps2_main_bus

sources:
  - include_dirs:
      - .
    files:
      - cps2_pkg.sv
      - cps2_bus_if.sv
      - cps2_sel_if.sv
      - cps2_addr_decode.sv
      - cps2_io_regs.sv
      - cps2_bus_cycle.sv
      - cps2_main_bus.sv
  - target: test
    include_dirs:
      - .
    files:
      - cps2_bus_checker.sv
      - tb_cps2_main_bus.sv
